/* include/cu_cfg.svh */
// Compute unit configuration
`ifndef CU_CFG_SVH
`define CU_CFG_SVH

// Memory interface widths
`define CU_ADDR_W 32
`define CU_DATA_W 64
// Tag is the line index inside one job
`define CU_TAG_W 8
`define CU_LEN_W 8

// Command buffer sizing
`define CU_CMD_DEPTH 4
`define CU_CNT_W $clog2(`CU_CMD_DEPTH + 1)

// Read throttle
// Kept at or below CU_CMD_DEPTH so returned data always finds write room
`define CU_MAX_OUTSTANDING 4

`endif

/* design/capi_pkg.sv */
// Memory interface types
`include "cu_cfg.svh"

package capi_pkg;

	// ----------------------------------------
	// Commands
	// ----------------------------------------

	typedef enum logic {
		cmd_read  = 1'b0,
		cmd_write = 1'b1
	} cmd_op_t;

	// One command slot
	typedef struct packed {
		logic                  valid;
		cmd_op_t               opcode;
		logic [`CU_TAG_W-1:0]  tag;
		logic [`CU_ADDR_W-1:0] address;
	} command_line_t;

	// Write command travels with its line
	typedef struct packed {
		command_line_t         cmd;
		logic [`CU_DATA_W-1:0] data;
	} write_entry_t;

	// ----------------------------------------
	// Responses and data
	// ----------------------------------------

	typedef struct packed {
		logic                 valid;
		logic [`CU_TAG_W-1:0] tag;
	} response_line_t;

	// Read return or write payload
	typedef struct packed {
		logic                  valid;
		logic [`CU_TAG_W-1:0]  tag;
		logic [`CU_DATA_W-1:0] data;
	} data_line_t;

	// Registered buffer occupancy
	typedef struct packed {
		logic                 empty;
		logic                 full;
		logic [`CU_CNT_W-1:0] count;
	} buffer_status_t;

endpackage

/* design/cu_pkg.sv */
// Compute unit types
`include "cu_cfg.svh"

package cu_pkg;

	// Work element descriptor
	// Valid is a one cycle pulse
	typedef struct packed {
		logic                  valid;
		logic [`CU_ADDR_W-1:0] src_addr;
		logic [`CU_ADDR_W-1:0] dst_addr;
		logic [`CU_LEN_W-1:0]  length;
	} wed_t;

	// Per line transform
	typedef enum logic [1:0] {
		op_copy   = 2'd0,
		op_invert = 2'd1,
		op_add    = 2'd2
	} cu_op_t;

	// Held stable while enabled
	typedef struct packed {
		cu_op_t                op;
		logic [`CU_DATA_W-1:0] operand;
	} cu_configure_t;

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_run  = 2'd1,
		st_done = 2'd2
	} cu_state_t;

	// Lines written back
	typedef struct packed {
		logic [`CU_LEN_W-1:0] lines_written;
	} cu_return_t;

endpackage

/* design/command_buffer.sv */
// Command FIFO
`timescale 1ns/100ps
`include "cu_cfg.svh"

module command_buffer #(
	parameter int WIDTH = 42
) (
	input  logic                     clock,
	input  logic                     arst_n,
	input  logic                     push,
	input  logic [WIDTH-1:0]         push_data,
	input  logic                     pop,
	output logic [WIDTH-1:0]         head_data,
	output capi_pkg::buffer_status_t status
);

	localparam int DEPTH = `CU_CMD_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0]     mem [DEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic                 do_push;
	logic                 do_pop;
	logic [`CU_CNT_W-1:0] count_next;

	// Overflow and underflow are dropped
	assign do_push = push && !status.full;
	assign do_pop  = pop && !status.empty;

	always_comb begin
		count_next = status.count;
		if (do_push && !do_pop) begin
			count_next = status.count + 1'b1;
		end else if (do_pop && !do_push) begin
			count_next = status.count - 1'b1;
		end
	end

	// ----------------------------------------
	// Storage and pointers
	// ----------------------------------------

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			// Wrap explicitly, depth need not be a power of two
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	// Status tracks occupancy after this edge
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			status <= '{empty: 1'b1, full: 1'b0, count: '0};
		end else begin
			status.count <= count_next;
			status.empty <= (count_next == '0);
			status.full  <= (count_next == `CU_CNT_W'(DEPTH));
		end
	end

	// Empty head reads as all zero so valid stays low
	assign head_data = status.empty ? '0 : mem[rd_ptr];

	// Producer must honour full
	a_no_push_full: assert property (@(posedge clock) disable iff (!arst_n)
		push |-> !status.full);
	// Consumer only pops a visible entry
	a_no_pop_empty: assert property (@(posedge clock) disable iff (!arst_n)
		pop |-> !status.empty);

endmodule

/* design/cu_control.sv */
// Compute unit control FSM
`timescale 1ns/100ps
`include "cu_cfg.svh"

module cu_control (
	input  logic                     clock,
	input  logic                     arst_n,
	input  logic                     enabled,
	input  cu_pkg::wed_t             wed_request,
	input  cu_pkg::cu_configure_t    cu_configure,
	input  capi_pkg::response_line_t read_response,
	input  capi_pkg::data_line_t     read_data,
	input  capi_pkg::response_line_t write_response,
	input  capi_pkg::buffer_status_t read_buffer_status,
	input  capi_pkg::buffer_status_t write_buffer_status,
	output logic                     read_command_push,
	output capi_pkg::command_line_t  read_command,
	output logic                     write_command_push,
	output capi_pkg::write_entry_t   write_entry,
	output logic                     cu_done,
	output cu_pkg::cu_return_t       cu_return,
	output logic [63:0]              cu_status
);

	localparam int LEN_W = `CU_LEN_W;
	// Room for outstanding plus buffered writes
	localparam int SUM_W = LEN_W + 2;

	cu_pkg::cu_state_t     state;
	cu_pkg::wed_t          wed_q;
	logic [LEN_W-1:0]      reads_issued;
	logic [LEN_W-1:0]      outstanding;
	logic [LEN_W-1:0]      writes_done;
	logic [SUM_W-1:0]      write_credit;
	logic                  start;
	logic                  issue;
	logic                  read_back;
	logic                  write_back;
	logic                  write_last;
	logic                  wr_push_q;
	logic [`CU_TAG_W-1:0]  wr_tag_q;
	logic [`CU_DATA_W-1:0] wr_data_q;
	logic [`CU_DATA_W-1:0] result;

	assign start      = (state == cu_pkg::st_idle) && enabled && wed_request.valid;
	assign read_back  = (state == cu_pkg::st_run) && read_response.valid;
	assign write_back = (state == cu_pkg::st_run) && write_response.valid;
	assign write_last = write_back && ((writes_done + 1'b1) == wed_q.length);

	// Every line in flight holds a future write buffer slot
	assign write_credit = SUM_W'(outstanding) + SUM_W'(write_buffer_status.count)
		+ SUM_W'(wr_push_q);

	// ----------------------------------------
	// Read issue
	// ----------------------------------------

	assign issue = (state == cu_pkg::st_run)
		&& (reads_issued < wed_q.length)
		&& !read_buffer_status.full
		&& (outstanding < LEN_W'(`CU_MAX_OUTSTANDING))
		&& (write_credit < SUM_W'(`CU_CMD_DEPTH));

	assign read_command_push = issue;

	always_comb begin
		read_command.valid   = issue;
		read_command.opcode  = capi_pkg::cmd_read;
		read_command.tag     = `CU_TAG_W'(reads_issued);
		// One line per tag
		read_command.address = wed_q.src_addr + `CU_ADDR_W'(reads_issued);
	end

	// ----------------------------------------
	// State and counters
	// ----------------------------------------

	always_ff @(posedge clock) begin
		if (start) begin
			wed_q <= wed_request;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state   <= cu_pkg::st_idle;
			cu_done <= 1'b0;
		end else begin
			case (state)
				cu_pkg::st_idle: begin
					if (start) begin
						state <= cu_pkg::st_run;
					end
				end
				cu_pkg::st_run: begin
					// Final write response closes the job
					if (write_last) begin
						state   <= cu_pkg::st_done;
						cu_done <= 1'b1;
					end
				end
				cu_pkg::st_done: begin
					if (!enabled) begin
						state   <= cu_pkg::st_idle;
						cu_done <= 1'b0;
					end
				end
				default: state <= cu_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			reads_issued <= '0;
			outstanding  <= '0;
			writes_done  <= '0;
		end else if (start) begin
			// Last job's counts stay visible until the next WED
			reads_issued <= '0;
			outstanding  <= '0;
			writes_done  <= '0;
		end else begin
			if (issue) begin
				reads_issued <= reads_issued + 1'b1;
			end
			if (write_back) begin
				writes_done <= writes_done + 1'b1;
			end
			if (issue && !read_back) begin
				outstanding <= outstanding + 1'b1;
			end else if (read_back && !issue) begin
				outstanding <= outstanding - 1'b1;
			end
		end
	end

	// ----------------------------------------
	// Transform and write entry
	// ----------------------------------------

	always_comb begin
		case (cu_configure.op)
			cu_pkg::op_copy:   result = read_data.data;
			cu_pkg::op_invert: result = ~read_data.data;
			// Wraps modulo 2^64
			cu_pkg::op_add:    result = read_data.data + cu_configure.operand;
			default:           result = read_data.data;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_push_q <= 1'b0;
		end else begin
			wr_push_q <= (state == cu_pkg::st_run) && read_data.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (read_data.valid) begin
			wr_tag_q  <= read_data.tag;
			wr_data_q <= result;
		end
	end

	assign write_command_push = wr_push_q;

	always_comb begin
		write_entry.cmd.valid   = wr_push_q;
		write_entry.cmd.opcode  = capi_pkg::cmd_write;
		write_entry.cmd.tag     = wr_tag_q;
		write_entry.cmd.address = wed_q.dst_addr + `CU_ADDR_W'(wr_tag_q);
		write_entry.data        = wr_data_q;
	end

	// Return and status words
	assign cu_return.lines_written = writes_done;
	assign cu_status = {{(64 - 2 - 2 * LEN_W){1'b0}}, state, reads_issued, writes_done};

	// Read throttle holds across the whole job
	a_outstanding_max: assert property (@(posedge clock) disable iff (!arst_n)
		outstanding <= LEN_W'(`CU_MAX_OUTSTANDING));
	// Credit scheme keeps the write buffer from overflowing
	a_write_room: assert property (@(posedge clock) disable iff (!arst_n)
		write_command_push |-> !write_buffer_status.full);
	a_done_state: assert property (@(posedge clock) disable iff (!arst_n)
		cu_done |-> (state == cu_pkg::st_done));

endmodule

/* design/cu_top.sv */
// Compute unit top level
`timescale 1ns/100ps

module cu_top (
	input  logic                     clock,
	input  logic                     arst_n,
	input  logic                     enabled,
	input  cu_pkg::wed_t             wed_request,
	input  cu_pkg::cu_configure_t    cu_configure,
	input  capi_pkg::response_line_t read_response,
	input  capi_pkg::data_line_t     read_data,
	input  capi_pkg::response_line_t write_response,
	input  logic                     read_command_pop,
	input  logic                     write_command_pop,
	output capi_pkg::command_line_t  read_command_out,
	output capi_pkg::command_line_t  write_command_out,
	output capi_pkg::data_line_t     write_data_out,
	output capi_pkg::buffer_status_t read_buffer_status,
	output capi_pkg::buffer_status_t write_buffer_status,
	output logic                     cu_done,
	output cu_pkg::cu_return_t       cu_return,
	output logic [63:0]              cu_status
);

	localparam int READ_W  = $bits(capi_pkg::command_line_t);
	localparam int WRITE_W = $bits(capi_pkg::write_entry_t);

	logic                    read_command_push;
	capi_pkg::command_line_t read_command;
	logic                    write_command_push;
	capi_pkg::write_entry_t  write_entry;
	capi_pkg::write_entry_t  write_head;

	// ----------------------------------------
	// Control
	// ----------------------------------------

	cu_control control (
		.clock               (clock),
		.arst_n              (arst_n),
		.enabled             (enabled),
		.wed_request         (wed_request),
		.cu_configure        (cu_configure),
		.read_response       (read_response),
		.read_data           (read_data),
		.write_response      (write_response),
		.read_buffer_status  (read_buffer_status),
		.write_buffer_status (write_buffer_status),
		.read_command_push   (read_command_push),
		.read_command        (read_command),
		.write_command_push  (write_command_push),
		.write_entry         (write_entry),
		.cu_done             (cu_done),
		.cu_return           (cu_return),
		.cu_status           (cu_status)
	);

	// ----------------------------------------
	// Command buffers
	// ----------------------------------------

	command_buffer #(.WIDTH(READ_W)) read_buffer (
		.clock     (clock),
		.arst_n    (arst_n),
		.push      (read_command_push),
		.push_data (read_command),
		.pop       (read_command_pop),
		.head_data (read_command_out),
		.status    (read_buffer_status)
	);

	command_buffer #(.WIDTH(WRITE_W)) write_buffer (
		.clock     (clock),
		.arst_n    (arst_n),
		.push      (write_command_push),
		.push_data (write_entry),
		.pop       (write_command_pop),
		.head_data (write_head),
		.status    (write_buffer_status)
	);

	// Head entry split into command and data lines
	assign write_command_out   = write_head.cmd;
	assign write_data_out.valid = write_head.cmd.valid;
	assign write_data_out.tag   = write_head.cmd.tag;
	assign write_data_out.data  = write_head.data;

endmodule

/* dv/cu_checker.sv */
// Compute unit scoreboard
`timescale 1ns/100ps
`include "cu_cfg.svh"

module cu_checker (
	input  logic                     clock,
	input  logic                     arst_n,
	input  logic                     enabled,
	input  cu_pkg::wed_t             wed_request,
	input  cu_pkg::cu_configure_t    cu_configure,
	input  capi_pkg::data_line_t     read_data,
	input  capi_pkg::response_line_t write_response,
	input  logic                     read_command_pop,
	input  logic                     write_command_pop,
	input  capi_pkg::command_line_t  read_command_out,
	input  capi_pkg::command_line_t  write_command_out,
	input  capi_pkg::data_line_t     write_data_out,
	input  capi_pkg::buffer_status_t read_buffer_status,
	input  capi_pkg::buffer_status_t write_buffer_status,
	input  logic                     cu_done,
	input  cu_pkg::cu_return_t       cu_return,
	input  logic [63:0]              cu_status,
	output int                       errors,
	output int                       checks,
	output int                       tests_done
);

	localparam int TAGS  = 1 << `CU_TAG_W;
	localparam int LEN_W = `CU_LEN_W;

	// Job under test
	cu_pkg::wed_t          job;
	cu_pkg::cu_configure_t cfg;
	// Per tag bookkeeping
	bit                    read_seen [TAGS];
	bit                    write_seen [TAGS];
	bit                    data_back [TAGS];
	logic [`CU_DATA_W-1:0] src_word [TAGS];
	int                    in_flight;
	int                    write_resps;
	int                    test_errors;
	bit                    running;
	bit                    done_due;
	bit                    in_done;
	bit                    done_prev;
	bit                    enabled_prev;
	// Buffer occupancy model
	int                    read_popped;
	int                    wcount_model;
	bit                    wpush_due;

	// Expected destination word
	function automatic logic [`CU_DATA_W-1:0] apply_op(input logic [`CU_DATA_W-1:0] word);
		case (cfg.op)
			cu_pkg::op_invert: return ~word;
			cu_pkg::op_add:    return word + cfg.operand;
			default:           return word;
		endcase
	endfunction

	function automatic string op_label(input cu_pkg::cu_op_t op);
		case (op)
			cu_pkg::op_invert: return "invert";
			cu_pkg::op_add:    return "add";
			default:           return "copy";
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [63:0] expected,
		input logic [63:0] got);
		checks++;
		if (got !== expected) begin
			errors++;
			test_errors++;
			$display("error %s expected %h got %h", name, expected, got);
		end
	endtask

	task automatic report_failure(input string msg);
		checks++;
		errors++;
		test_errors++;
		$display("%s", msg);
	endtask

	// ----------------------------------------
	// Job start and end
	// ----------------------------------------

	task automatic start_job();
		job = wed_request;
		cfg = cu_configure;
		for (int i = 0; i < TAGS; i++) begin
			read_seen[i]  = 1'b0;
			write_seen[i] = 1'b0;
			data_back[i]  = 1'b0;
		end
		in_flight   = 0;
		write_resps = 0;
		test_errors = 0;
		read_popped = 0;
		running     = 1'b1;
		done_due    = 1'b0;
	endtask

	task automatic finish_job();
		for (int i = 0; i < int'(job.length); i++) begin
			if (!read_seen[i]) begin
				report_failure($sformatf("tag %h was never read", i[`CU_TAG_W-1:0]));
			end
			if (!write_seen[i]) begin
				report_failure($sformatf("tag %h was never written", i[`CU_TAG_W-1:0]));
			end
		end
		compare_value("cu_return", job.length, cu_return.lines_written);
		// Status word packs state, reads issued, writes completed
		compare_value("cu_status.writes", job.length, cu_status[LEN_W-1:0]);
		compare_value("cu_status.reads", job.length, cu_status[2*LEN_W-1:LEN_W]);
		compare_value("cu_status.state", cu_pkg::st_done, cu_status[2*LEN_W+1:2*LEN_W]);
		$display("test %0d op %s length %0d %s", tests_done, op_label(cfg.op), job.length,
			(test_errors == 0) ? "ok" : "failed");
		tests_done++;
		done_due = 1'b0;
		in_done  = 1'b1;
		running  = 1'b0;
	endtask

	// ----------------------------------------
	// Buffer status checks
	// ----------------------------------------

	// Registered status against pops seen and modelled pushes
	task automatic check_buffers();
		compare_value("read_buffer_status.empty", !read_command_out.valid,
			read_buffer_status.empty);
		compare_value("read_buffer_status.full",
			int'(read_buffer_status.count) == `CU_CMD_DEPTH, read_buffer_status.full);
		// Popped plus queued reads never pass the job length
		if (running && (read_popped + int'(read_buffer_status.count) > int'(job.length))) begin
			report_failure("read buffer holds more commands than the job has lines");
		end
		compare_value("write_buffer_status.count", wcount_model, write_buffer_status.count);
		compare_value("write_buffer_status.empty", wcount_model == 0,
			write_buffer_status.empty);
		compare_value("write_buffer_status.full", wcount_model == `CU_CMD_DEPTH,
			write_buffer_status.full);
	endtask

	// ----------------------------------------
	// Command checks
	// ----------------------------------------

	task automatic check_read();
		logic [`CU_TAG_W-1:0]  tag;
		logic [`CU_ADDR_W-1:0] exp_addr;
		tag      = read_command_out.tag;
		exp_addr = job.src_addr + tag;
		compare_value("read_command_out.opcode", capi_pkg::cmd_read, read_command_out.opcode);
		compare_value("read_command_out.address", exp_addr, read_command_out.address);
		if (tag >= job.length) begin
			report_failure($sformatf("read tag %h lies beyond the job length", tag));
		end else if (read_seen[tag]) begin
			report_failure($sformatf("read tag %h was issued twice", tag));
		end
		read_seen[tag] = 1'b1;
		in_flight++;
		read_popped++;
	endtask

	task automatic check_write();
		logic [`CU_TAG_W-1:0]  tag;
		logic [`CU_ADDR_W-1:0] exp_addr;
		tag      = write_command_out.tag;
		exp_addr = job.dst_addr + tag;
		compare_value("write_command_out.opcode", capi_pkg::cmd_write, write_command_out.opcode);
		compare_value("write_command_out.address", exp_addr, write_command_out.address);
		compare_value("write_data_out.valid", 1'b1, write_data_out.valid);
		compare_value("write_data_out.tag", tag, write_data_out.tag);
		if (tag >= job.length) begin
			report_failure($sformatf("write tag %h lies beyond the job length", tag));
		end else if (!data_back[tag]) begin
			report_failure($sformatf("write for tag %h came before its read data", tag));
		end else begin
			compare_value("write_data_out.data", apply_op(src_word[tag]), write_data_out.data);
		end
		if (write_seen[tag]) begin
			report_failure($sformatf("tag %h was written twice", tag));
		end
		write_seen[tag] = 1'b1;
	endtask

	// ----------------------------------------
	// Port watcher
	// ----------------------------------------

	// Inputs change on the falling edge and have settled by this edge
	always @(posedge clock) begin : watch
		logic [`CU_TAG_W-1:0] tag;
		if (!arst_n) begin
			errors       = 0;
			checks       = 0;
			tests_done   = 0;
			running      = 1'b0;
			done_due     = 1'b0;
			in_done      = 1'b0;
			done_prev    = 1'b0;
			enabled_prev = 1'b0;
			in_flight    = 0;
			read_popped  = 0;
			wcount_model = 0;
			wpush_due    = 1'b0;
		end else begin
			if (enabled && wed_request.valid && !running) begin
				start_job();
			end
			check_buffers();
			// Done is due one cycle after the final write response
			if (done_due) begin
				compare_value("cu_done", 1'b1, cu_done);
				finish_job();
			end else if (cu_done && !done_prev) begin
				report_failure("cu_done rose before the last write response");
			end
			if (in_done && enabled && !cu_done) begin
				report_failure("cu_done fell while enabled was still high");
			end
			if (!enabled) begin
				in_done = 1'b0;
			end
			if (!enabled_prev && cu_done) begin
				report_failure("cu_done stayed high after enabled fell");
			end
			// Returns are taken before new pops as in the memory model
			if (read_data.valid) begin
				tag = read_data.tag;
				data_back[tag] = 1'b1;
				src_word[tag]  = read_data.data;
				in_flight--;
			end
			if (read_command_pop && read_command_out.valid) begin
				check_read();
			end
			if (in_flight > `CU_MAX_OUTSTANDING) begin
				report_failure($sformatf("%0d reads in flight, more than allowed", in_flight));
			end
			if (write_command_pop && write_command_out.valid) begin
				check_write();
			end
			if (write_response.valid && running) begin
				write_resps++;
				if (write_resps == int'(job.length)) begin
					done_due = 1'b1;
				end
			end
			// Write entry lands one cycle after its read data
			wcount_model = wcount_model + int'(wpush_due)
				- int'(write_command_pop && write_command_out.valid);
			wpush_due    = read_data.valid;
			done_prev    = cu_done;
			enabled_prev = enabled;
		end
	end

endmodule

/* dv/cu_tb.sv */
// Compute unit testbench
`timescale 1ns/100ps
`include "cu_cfg.svh"

module cu_tb;

	localparam int NUM_TESTS = 9;
	localparam int MAX_LEN   = 16;

	logic                     clock = 1'b0;
	logic                     arst_n = 1'b0;
	logic                     enabled = 1'b0;
	cu_pkg::wed_t             wed_request = '0;
	cu_pkg::cu_configure_t    cu_configure = '0;
	// Memory side, driven only by the memory model
	capi_pkg::response_line_t read_response = '0;
	capi_pkg::data_line_t     read_data = '0;
	capi_pkg::response_line_t write_response = '0;
	logic                     read_command_pop = 1'b0;
	logic                     write_command_pop = 1'b0;
	capi_pkg::command_line_t  read_command_out;
	capi_pkg::command_line_t  write_command_out;
	capi_pkg::data_line_t     write_data_out;
	capi_pkg::buffer_status_t read_buffer_status;
	capi_pkg::buffer_status_t write_buffer_status;
	logic                     cu_done;
	cu_pkg::cu_return_t       cu_return;
	logic [63:0]              cu_status;
	int                       errors;
	int                       checks;
	int                       tests_done;

	// Job table, all drawn at time zero
	integer                  seed;
	logic [`CU_LEN_W-1:0]    test_len [NUM_TESTS];
	logic [`CU_ADDR_W-1:0]   test_src [NUM_TESTS];
	logic [`CU_ADDR_W-1:0]   test_dst [NUM_TESTS];
	logic [`CU_DATA_W-1:0]   test_operand [NUM_TESTS];
	int                      pop_pct [NUM_TESTS];
	int                      resp_pct [NUM_TESTS];
	int                      hold [NUM_TESTS];
	logic [`CU_DATA_W-1:0]   src_words [NUM_TESTS][MAX_LEN];
	int                      cur_test = 0;
	int                      cycle_count = 0;
	int                      cycle_limit = 1000;
	capi_pkg::command_line_t read_pending [$];
	capi_pkg::command_line_t write_pending [$];

	cu_top dut (.*);

	cu_checker check_unit (.*);

	always #20 clock = ~clock;

	function automatic bit chance(input int pct);
		return ({$random(seed)} % 100) < pct;
	endfunction

	// ----------------------------------------
	// Memory model
	// ----------------------------------------

	always @(negedge clock) begin : memory_model
		int                      idx;
		capi_pkg::command_line_t cmd;
		read_response     = '0;
		read_data         = '0;
		write_response    = '0;
		read_command_pop  = 1'b0;
		write_command_pop = 1'b0;
		if (arst_n) begin
			// Random pending read, so returns come out of order
			if (read_pending.size() > 0 && chance(resp_pct[cur_test])) begin
				idx = {$random(seed)} % read_pending.size();
				cmd = read_pending[idx];
				read_pending.delete(idx);
				read_response.valid = 1'b1;
				read_response.tag   = cmd.tag;
				read_data.valid     = 1'b1;
				read_data.tag       = cmd.tag;
				read_data.data      = src_words[cur_test][4'(cmd.address - test_src[cur_test])];
			end
			if (write_pending.size() > 0 && chance(resp_pct[cur_test])) begin
				idx = {$random(seed)} % write_pending.size();
				write_response.valid = 1'b1;
				write_response.tag   = write_pending[idx].tag;
				write_pending.delete(idx);
			end
			// Withheld pops give back-pressure
			if (read_command_out.valid && chance(pop_pct[cur_test])) begin
				read_command_pop = 1'b1;
				read_pending.push_back(read_command_out);
			end
			if (write_command_out.valid && chance(pop_pct[cur_test])) begin
				write_command_pop = 1'b1;
				write_pending.push_back(write_command_out);
			end
		end
	end

	// Run limit scales with total line count
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, a job never completed", cycle_count);
			$display("TB FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------

	task automatic run_job(input int t);
		cur_test              = t;
		cu_configure.op       = cu_pkg::cu_op_t'(t % 3);
		cu_configure.operand  = test_operand[t];
		enabled               = 1'b1;
		@(negedge clock);
		wed_request.valid     = 1'b1;
		wed_request.src_addr  = test_src[t];
		wed_request.dst_addr  = test_dst[t];
		wed_request.length    = test_len[t];
		@(negedge clock);
		wed_request.valid = 1'b0;
		while (!cu_done) begin
			@(negedge clock);
		end
		// Done must hold while enabled stays high
		repeat (hold[t]) @(negedge clock);
		enabled = 1'b0;
		repeat (3) @(negedge clock);
	endtask

	initial begin : stimulus
		int total;
		seed  = 32'h3416_b5c4;
		total = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			test_len[t]     = `CU_LEN_W'(1 + {$random(seed)} % MAX_LEN);
			test_src[t]     = $random(seed);
			test_dst[t]     = $random(seed);
			test_operand[t] = {$random(seed), $random(seed)};
			// Middle three jobs run under heavy back-pressure
			pop_pct[t]      = (t >= 3 && t < 6) ? 25 : 40 + {$random(seed)} % 61;
			resp_pct[t]     = 20 + {$random(seed)} % 71;
			hold[t]         = 1 + {$random(seed)} % 6;
			for (int i = 0; i < MAX_LEN; i++) begin
				src_words[t][i] = {$random(seed), $random(seed)};
			end
			total += int'(test_len[t]);
		end
		cycle_limit = 200 * total + 1000;
		repeat (3) @(negedge clock);
		arst_n = 1'b1;
		repeat (2) @(negedge clock);
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_job(t);
		end
		$display("tests %0d checks %0d errors %0d", tests_done, checks, errors);
		if (errors == 0 && tests_done == NUM_TESTS) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+include
design/capi_pkg.sv
design/cu_pkg.sv
design/command_buffer.sv
design/cu_control.sv
design/cu_top.sv
dv/cu_checker.sv
dv/cu_tb.sv

/* Bender.yml */
package:
  name: capi_cu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/capi_pkg.sv
      - design/cu_pkg.sv
      - design/command_buffer.sv
      - design/cu_control.sv
      - design/cu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/cu_checker.sv
      - dv/cu_tb.sv
